/* include/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Data word and CPU address widths
`define DCACHE_WORD_W   32
`define DCACHE_ADDR_W   32

// Two ways of 8 sets with one LRU bit per set
`define DCACHE_SETS     8
`define DCACHE_INDEX_W  3

// Address bits above index, block offset and byte offset
`define DCACHE_TAG_W    26

// Frame slots visited by the flush walk starting with way 0
`define DCACHE_SLOTS    16

`endif

/* rtl/dcache_array.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_array (
  input  logic                      CLK,
  input  logic                      nRST,
  input  dcache_pkg::cpu_req_t      cpu,
  input  dcache_pkg::dcache_state_t state,
  input  logic                      beat,
  input  dcache_pkg::slot_t         slot,
  input  dcache_pkg::word_t         dload,
  output logic                      dhit,
  output dcache_pkg::word_t         dmemload,
  output logic                      miss,
  output logic                      victim_dirty,
  output logic                      slot_dirty,
  output dcache_pkg::word_t         addr,
  output dcache_pkg::word_t         store
);

  import dcache_pkg::*;

  dcache_frame_t [`DCACHE_SETS-1:0][1:0] frames;
  logic [`DCACHE_SETS-1:0]               lru;

  dcache_addr_t a;
  idx_t         idx;
  idx_t         sidx;
  logic         sway;
  logic         req;
  logic         hit0;
  logic         hit1;
  logic         hit_way;
  logic         vway;
  logic         second;

  assign a    = cpu.addr;
  assign idx  = a.idx;
  assign req  = cpu.ren || cpu.wen;

  // Top bit of the flush slot is the way
  assign sidx = slot[`DCACHE_INDEX_W-1:0];
  assign sway = slot[`DCACHE_INDEX_W];

  // Tag compare on both ways
  assign hit0 = frames[idx][0].valid && (frames[idx][0].tag == a.tag);
  assign hit1 = frames[idx][1].valid && (frames[idx][1].tag == a.tag);
  assign hit_way = !hit0;

  assign dhit = (state == IDLE) && req && (hit0 || hit1);
  assign miss = (state == IDLE) && req && !(hit0 || hit1);

  assign dmemload = (dhit && !cpu.wen) ? frames[idx][hit_way].data[a.blkoff] : '0;

  // Invalid way first and the LRU way otherwise
  always_comb begin
    if (!frames[idx][0].valid) begin
      vway = 1'b0;
    end else if (!frames[idx][1].valid) begin
      vway = 1'b1;
    end else begin
      vway = lru[idx];
    end
  end

  assign victim_dirty = frames[idx][vway].dirty;
  assign slot_dirty   = frames[sidx][sway].dirty;

  // Second word of the block on the second beat
  assign second = (state == WB1) || (state == LOAD1) || (state == WRITE1);

  // Bus address and store word
  always_comb begin
    addr  = '0;
    store = '0;
    case (state)
      WB0, WB1: begin
        addr  = {frames[idx][vway].tag, idx, second, 2'b00};
        store = frames[idx][vway].data[second];
      end
      LOAD0, LOAD1: begin
        addr = {a.tag, idx, second, 2'b00};
      end
      WRITE0, WRITE1: begin
        addr  = {frames[sidx][sway].tag, sidx, second, 2'b00};
        store = frames[sidx][sway].data[second];
      end
      default: begin
        addr  = '0;
        store = '0;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      frames <= '0;
      lru    <= '0;
    end else begin
      // Other way becomes LRU on a hit
      if (dhit) begin
        lru[idx] <= ~hit_way;
        if (cpu.wen) begin
          frames[idx][hit_way].data[a.blkoff] <= cpu.store;
          frames[idx][hit_way].dirty          <= 1'b1;
        end
      end
      if (beat) begin
        case (state)
          WB1: begin
            frames[idx][vway].valid <= 1'b0;
            frames[idx][vway].dirty <= 1'b0;
          end
          LOAD0, LOAD1: begin
            frames[idx][vway].data[second] <= dload;
            // Frame goes live with the last fill word
            if (state == LOAD1) begin
              frames[idx][vway].tag   <= a.tag;
              frames[idx][vway].valid <= 1'b1;
              frames[idx][vway].dirty <= 1'b0;
            end
          end
          WRITE1: begin
            frames[sidx][sway].valid <= 1'b0;
            frames[sidx][sway].dirty <= 1'b0;
          end
          default: begin
            frames <= frames;
          end
        endcase
      end
    end
  end

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      req,
  input  logic                      halt,
  input  logic                      miss,
  input  logic                      victim_dirty,
  input  logic                      slot_dirty,
  input  logic                      flush_end,
  input  logic                      dwait,
  output dcache_pkg::dcache_state_t state,
  output logic                      beat,
  output logic                      step,
  output logic                      ren,
  output logic                      wen,
  output logic                      flushed
);

  import dcache_pkg::*;

  dcache_state_t next_state;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Bus strobes follow the state directly
  always_comb begin
    ren = 1'b0;
    wen = 1'b0;
    case (state)
      LOAD0, LOAD1: begin
        ren = 1'b1;
      end
      WB0, WB1, WRITE0, WRITE1: begin
        wen = 1'b1;
      end
      default: begin
        ren = 1'b0;
        wen = 1'b0;
      end
    endcase
  end

  // A beat completes when the bus drops dwait
  assign beat = (ren || wen) && !dwait;

  assign flushed = (state == DONE);

  always_comb begin
    next_state = state;
    step       = 1'b0;
    case (state)
      IDLE: begin
        // Halt wins over a pending request
        if (halt) begin
          next_state = FLUSH;
        end else if (req && miss) begin
          next_state = victim_dirty ? WB0 : LOAD0;
        end
      end
      WB0: begin
        if (!dwait) begin
          next_state = WB1;
        end
      end
      WB1: begin
        if (!dwait) begin
          next_state = LOAD0;
        end
      end
      LOAD0: begin
        if (!dwait) begin
          next_state = LOAD1;
        end
      end
      // Back to IDLE, where the request now hits
      LOAD1: begin
        if (!dwait) begin
          next_state = IDLE;
        end
      end
      FLUSH: begin
        if (flush_end) begin
          next_state = DONE;
        end else if (slot_dirty) begin
          next_state = WRITE0;
        end else begin
          // Skip a clean slot
          step = 1'b1;
        end
      end
      WRITE0: begin
        if (!dwait) begin
          next_state = WRITE1;
        end
      end
      WRITE1: begin
        if (!dwait) begin
          next_state = FLUSH;
          step       = 1'b1;
        end
      end
      // Stays here until reset
      DONE: begin
        next_state = DONE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

/* rtl/dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

  typedef logic [`DCACHE_WORD_W-1:0]  word_t;
  typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
  typedef logic [`DCACHE_INDEX_W-1:0] idx_t;

  // Way in the top bit and set in the low bits
  typedef logic [`DCACHE_INDEX_W:0]   slot_t;

  // CPU byte address split into its cache fields
  typedef struct packed {
    tag_t                                                    tag;
    idx_t                                                    idx;
    logic                                                    blkoff;
    logic [`DCACHE_ADDR_W-`DCACHE_TAG_W-`DCACHE_INDEX_W-2:0] bytoff;
  } dcache_addr_t;

  typedef struct packed {
    logic        valid;
    logic        dirty;
    tag_t        tag;
    word_t [1:0] data;
  } dcache_frame_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } cpu_req_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

  typedef enum logic [3:0] {
    IDLE, WB0, WB1, LOAD0, LOAD1, FLUSH, WRITE0, WRITE1, DONE
  } dcache_state_t;

endpackage

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  dcache_pkg::cpu_req_t cpu,
  input  logic                 halt,
  output logic                 dhit,
  output dcache_pkg::word_t    dmemload,
  output logic                 flushed,
  output dcache_pkg::mem_req_t mem,
  input  dcache_pkg::word_t    dload,
  input  logic                 dwait
);

  import dcache_pkg::*;

  dcache_state_t state;
  slot_t         slot;
  word_t         mem_addr;
  word_t         mem_store;
  logic          beat;
  logic          step;
  logic          miss;
  logic          victim_dirty;
  logic          slot_dirty;
  logic          flush_end;
  logic          mem_ren;
  logic          mem_wen;

  // Bus request assembled from controller strobes and array datapath
  assign mem = '{ren: mem_ren, wen: mem_wen, addr: mem_addr, store: mem_store};

  dcache_ctrl ctrl (
    .CLK          (CLK),
    .nRST         (nRST),
    .req          (cpu.ren || cpu.wen),
    .halt         (halt),
    .miss         (miss),
    .victim_dirty (victim_dirty),
    .slot_dirty   (slot_dirty),
    .flush_end    (flush_end),
    .dwait        (dwait),
    .state        (state),
    .beat         (beat),
    .step         (step),
    .ren          (mem_ren),
    .wen          (mem_wen),
    .flushed      (flushed)
  );

  flush_counter counter (
    .CLK       (CLK),
    .nRST      (nRST),
    .step      (step),
    .slot      (slot),
    .flush_end (flush_end)
  );

  dcache_array array (
    .CLK          (CLK),
    .nRST         (nRST),
    .cpu          (cpu),
    .state        (state),
    .beat         (beat),
    .slot         (slot),
    .dload        (dload),
    .dhit         (dhit),
    .dmemload     (dmemload),
    .miss         (miss),
    .victim_dirty (victim_dirty),
    .slot_dirty   (slot_dirty),
    .addr         (mem_addr),
    .store        (mem_store)
  );

endmodule

/* rtl/flush_counter.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module flush_counter (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              step,
  output dcache_pkg::slot_t slot,
  output logic              flush_end
);

  // One extra bit marks the end of the walk
  localparam int CNT_W = $clog2(`DCACHE_SLOTS) + 1;

  logic [CNT_W-1:0] count;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (step && !flush_end) begin
      count <= count + 1'b1;
    end
  end

  // Way 0 slots come before way 1
  assign slot = count[CNT_W-2:0];

  // Past the last slot
  assign flush_end = (count >= CNT_W'(`DCACHE_SLOTS));

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f sources.f --top-module dcache_tb -o dcache_sim \
  && ./obj_dir/dcache_sim | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "TEST RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* sources.f */
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/flush_counter.sv
rtl/dcache_array.sv
rtl/dcache_top.sv
test/tb_clock.sv
test/dcache_sva.sv
test/dcache_tb.sv

/* test/dcache_sva.sv */
`timescale 1ns/1ps

module dcache_sva (
  input logic                      CLK,
  input logic                      nRST,
  input dcache_pkg::dcache_state_t state,
  input dcache_pkg::mem_req_t      mem,
  input logic                      dwait,
  input logic                      dhit,
  input logic                      flushed
);

  import dcache_pkg::*;

  // Bus request frozen while the memory stalls
  property mem_held;
    @(posedge CLK) disable iff (!nRST)
      ((mem.ren || mem.wen) && dwait) |=> $stable(mem);
  endproperty

  property strobes_exclusive;
    @(posedge CLK) disable iff (!nRST)
      !(mem.ren && mem.wen);
  endproperty

  property hit_in_idle;
    @(posedge CLK) disable iff (!nRST)
      dhit |-> (state == IDLE);
  endproperty

  // Sticky until reset
  property flushed_sticky;
    @(posedge CLK) disable iff (!nRST)
      flushed |=> flushed;
  endproperty

  a_mem_held: assert property (mem_held)
    else $error("Bus request changed while dwait was high");
  a_strobes: assert property (strobes_exclusive)
    else $error("Bus ren and wen high in the same cycle");
  a_hit_idle: assert property (hit_in_idle)
    else $error("dhit high outside IDLE");
  a_flushed: assert property (flushed_sticky)
    else $error("flushed dropped after it was raised");

endmodule

bind dcache_top dcache_sva sva (
  .CLK     (CLK),
  .nRST    (nRST),
  .state   (state),
  .mem     (mem),
  .dwait   (dwait),
  .dhit    (dhit),
  .flushed (flushed)
);

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

  import dcache_pkg::*;

  localparam int TD_WORDS  = 256;
  localparam int MEM_WORDS = 1024;

  logic     CLK;
  logic     nRST;
  cpu_req_t cpu;
  logic     halt;
  logic     dhit;
  word_t    dmemload;
  logic     flushed;
  mem_req_t mem;
  word_t    dload;
  logic     dwait;

  // Four words per record for op, address, store data and expected load
  logic [31:0] td [0:TD_WORDS-1];
  word_t       mem_model [0:MEM_WORDS-1];
  word_t       shadow [0:MEM_WORDS-1];
  logic        written [0:MEM_WORDS-1];
  logic [15:0] lfsr;
  int          wait_left;
  int          rd_beats;
  int          n_records = 0;
  int          checks = 0;
  int          errors = 0;

  tb_clock clkgen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  dcache_top uut (
    .CLK      (CLK),
    .nRST     (nRST),
    .cpu      (cpu),
    .halt     (halt),
    .dhit     (dhit),
    .dmemload (dmemload),
    .flushed  (flushed),
    .mem      (mem),
    .dload    (dload),
    .dwait    (dwait)
  );

  assign dload = mem_model[mem.addr[11:2]];

  // Power-up memory content at a word index
  function automatic word_t initial_word(input int widx);
    return (32'(widx) << 2) ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic int take_bits(input int n);
    int r;
    int i;
    r = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = (r << 1) | {31'b0, lfsr[0]};
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input logic [3:0] id, input int errs, input int beats);
    $display("Test %0d finished: %0d errors, %0d bus read beats", id, errs, beats);
  endtask

  // Memory model updated on completed beats
  initial begin : memory
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] <= initial_word(i);
    end
    rd_beats <= 0;
    forever begin
      @(posedge CLK);
      if (mem.wen && !dwait) begin
        mem_model[mem.addr[11:2]] <= mem.store;
      end
      if (mem.ren && !dwait) begin
        rd_beats <= rd_beats + 1;
      end
    end
  end

  // Random stall of 0 to 3 cycles before each beat
  initial begin : stalls
    dwait = 1'b0;
    wait_left = 0;
    lfsr = 16'd4331;
    forever begin
      @(posedge CLK);
      #1;
      if (!nRST || !(mem.ren || mem.wen)) begin
        dwait = 1'b0;
      end else if (wait_left > 0) begin
        dwait = 1'b1;
        wait_left--;
      end else begin
        dwait = 1'b0;
        wait_left = take_bits(2);
      end
    end
  end

  task automatic cpu_access(input logic is_write, input word_t addr, input word_t store,
                            input word_t expect_load, input logic [3:0] exp_beats);
    int    beats0;
    int    cycles;
    word_t got;
    logic [9:0] widx;
    widx = addr[11:2];
    @(posedge CLK);
    #1;
    cpu.ren   = !is_write;
    cpu.wen   = is_write;
    cpu.addr  = addr;
    cpu.store = is_write ? store : '0;
    beats0 = rd_beats;
    cycles = 0;
    @(negedge CLK);
    while (!dhit && cycles < 200) begin
      @(negedge CLK);
      cycles++;
    end
    if (!dhit) begin
      errors++;
      $display("Access to %h got no dhit within 200 cycles", addr);
    end else begin
      got = dmemload;
      if (is_write) begin
        shadow[widx]  = store;
        written[widx] = 1'b1;
      end else begin
        compare("dmemload", got, expect_load);
        compare("dmemload vs shadow", got, shadow[widx]);
      end
      if (exp_beats != 4'hF) begin
        compare("read_beats", 32'(rd_beats - beats0), 32'(exp_beats));
      end
    end
    @(posedge CLK);
    #1;
    cpu = '0;
  endtask

  task automatic flush_and_check();
    int cycles;
    int i;
    @(posedge CLK);
    #1;
    halt = 1'b1;
    cycles = 0;
    @(negedge CLK);
    while (!flushed && cycles < 1000) begin
      @(negedge CLK);
      cycles++;
    end
    if (!flushed) begin
      errors++;
      $display("flushed did not rise within 1000 cycles of halt");
    end else begin
      // Every written word must now be in memory
      for (i = 0; i < MEM_WORDS; i++) begin
        if (written[i]) begin
          compare($sformatf("mem[%h]", i * 4), mem_model[i], shadow[i]);
        end
      end
    end
  endtask

  initial begin : stimulus
    int          r;
    int          i;
    int          test_err0;
    int          test_beats0;
    logic [31:0] opw;
    logic [3:0]  cur_test;
    cpu  = '0;
    halt = 1'b0;
    for (i = 0; i < MEM_WORDS; i++) begin
      shadow[i]  = initial_word(i);
      written[i] = 1'b0;
    end
    $readmemh("test/dcache_testdata.txt", td);
    r = 0;
    while (r < TD_WORDS / 4 && td[4 * r][3:0] !== 4'hF) begin
      r++;
    end
    n_records = r;
    if (n_records == 0) begin
      errors++;
      $display("No records found in test/dcache_testdata.txt");
    end
    wait (nRST === 1'b1);
    cur_test    = td[0][15:12];
    test_err0   = 0;
    test_beats0 = rd_beats;
    for (r = 0; r < n_records; r++) begin
      opw = td[4 * r];
      if (opw[15:12] != cur_test) begin
        report_test(cur_test, errors - test_err0, rd_beats - test_beats0);
        cur_test    = opw[15:12];
        test_err0   = errors;
        test_beats0 = rd_beats;
      end
      case (opw[3:0])
        4'h0: cpu_access(1'b0, td[4 * r + 1], td[4 * r + 2], td[4 * r + 3], opw[11:8]);
        4'h1: cpu_access(1'b1, td[4 * r + 1], td[4 * r + 2], td[4 * r + 3], opw[11:8]);
        4'h2: flush_and_check();
        default: begin
          errors++;
          $display("Unknown operation code %h in record %0d", opw[3:0], r);
        end
      endcase
    end
    report_test(cur_test, errors - test_err0, rd_beats - test_beats0);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // 40 cycles of budget per record
  initial begin : watchdog
    wait (n_records > 0);
    #(n_records * 40 * 40);
    $display("Watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* test/dcache_testdata.txt */
// Columns: op address store_data expected_load (hex)
// op bits: [15:12] test, [11:8] bus read beats (F unchecked), [3:0] 0 read 1 write 2 halt F end
// Test 1: read miss, then the other word of the block
00001200 00000008 00000000 A5A50008
00001000 0000000C 00000000 A5A5000C
// Test 2: write, then read back
00002201 00000010 11112222 00000000
00002000 00000010 00000000 11112222
// Test 3: dirty evictions in set 3
00003201 00000018 33330001 00000000
00003201 00000058 33330002 00000000
00003200 00000098 00000000 A5A50098
00003200 00000018 00000000 33330001
00003200 00000058 00000000 33330002
// Test 4: LRU order in set 4
00004200 00000020 00000000 A5A50020
00004200 00000060 00000000 A5A50060
00004000 00000020 00000000 A5A50020
00004200 000000A0 00000000 A5A500A0
00004000 00000020 00000000 A5A50020
00004200 00000060 00000000 A5A50060
// Test 5: mixed traffic under random stalls
00005F01 00000028 55550001 00000000
00005F00 0000002C 00000000 A5A5002C
00005F01 00000068 55550002 00000000
00005F01 000000A8 55550003 00000000
00005F00 00000028 00000000 55550001
00005F00 00000068 00000000 55550002
00005F00 000000A8 00000000 55550003
00005F01 00000030 55550004 00000000
00005F00 00000034 00000000 A5A50034
00005F00 00000030 00000000 55550004
00005F00 00000010 00000000 11112222
00005F00 000001F8 00000000 A5A501F8
00005F01 0000005C 55550005 00000000
// Test 6: halt and flush
00006F02 00000000 00000000 00000000
// End marker
0000000F 00000000 00000000 00000000

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic nRST
);

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Reset held low for three rising edges
  initial begin
    nRST = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule
